//--- hw/core_pkg.sv
// shared widths, opcode fields and control encodings for the rv32i subset core
// every rtl block refers to these by scoped name
package core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef enum logic [1:0] {
		HOLD_NONE  = 2'd0,	// everything advances
		HOLD_FETCH = 2'd1,	// pc held, bubble into id/ex
		HOLD_ALL   = 2'd2	// full freeze, no reg writes
	} hold_code_t;

	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_PASS_B = 3'd5	// lui
	} alu_op_t;

	typedef enum logic [1:0] {
		JMP_NONE = 2'd0,
		JMP_BEQ  = 2'd1,
		JMP_BNE  = 2'd2,
		JMP_JAL  = 2'd3
	} jmp_flag_t;

	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [2:0] F3_WORD    = 3'b010;	// lw and sw

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

//--- hw/pc.sv
// fetch address register of the core
// advances by one word, takes the redirect target from ctrl, holds on any hold code
`timescale 1ns/1ps

module pc #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  core_pkg::hold_code_t      hold_code_i,
	input  logic                      jmp_en_i,
	input  logic [core_pkg::XLEN-1:0] jmp_to_i,
	output logic [core_pkg::XLEN-1:0] pc_o,
	output logic                      instr_rd_en_o
);

	logic advance;

	assign advance = (hold_code_i == core_pkg::HOLD_NONE);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o <= RESET_PC;
		end else if (advance) begin
			if (jmp_en_i)
				pc_o <= jmp_to_i;	// taken branch or jal
			else
				pc_o <= pc_o + 32'd4;
		end
	end

	assign instr_rd_en_o = advance;	// memory keeps its word while held

endmodule

//--- hw/regs.sv
// integer register file, two combinational read ports and one write port
// x0 reads as zero, a read of the register being written returns the new value
`timescale 1ns/1ps

module regs (
	input  logic                            clk,
	input  logic                            arst_n_i,
	input  logic                            wr_en_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] addr_wr_i,
	input  logic [core_pkg::XLEN-1:0]       data_wr_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] addr_rd1_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] addr_rd2_i,
	output logic [core_pkg::XLEN-1:0]       data_rd1_o,
	output logic [core_pkg::XLEN-1:0]       data_rd2_o
);

	localparam int NREGS = 2 ** core_pkg::REG_ADDR_W;

	logic [core_pkg::XLEN-1:0] rf [NREGS];
	logic                      wr_live;

	assign wr_live = wr_en_i && (addr_wr_i != '0);	// x0 never written

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NREGS; i++)
				rf[i] <= '0;
		end else if (wr_live) begin
			rf[addr_wr_i] <= data_wr_i;
		end
	end

	assign data_rd1_o = (wr_live && addr_wr_i == addr_rd1_i) ? data_wr_i : rf[addr_rd1_i];
	assign data_rd2_o = (wr_live && addr_wr_i == addr_rd2_i) ? data_wr_i : rf[addr_rd2_i];

endmodule

//--- hw/id_stage.sv
// decode stage with the id/ex pipeline register
// decodes the fetched word, builds immediates, picks forwarded operands and hands
// branch operands to ctrl; a masked word or a load-use hold turns into a bubble
`timescale 1ns/1ps

module id_stage (
	input  logic                            clk,
	input  logic                            arst_n_i,
	input  core_pkg::hold_code_t            hold_code_i,
	input  logic                            instr_mask_i,
	input  logic [31:0]                     instr_i,
	input  logic [core_pkg::XLEN-1:0]       addr_instr_i,
	input  logic [core_pkg::XLEN-1:0]       data_rs1_i,
	input  logic [core_pkg::XLEN-1:0]       data_rs2_i,
	input  logic [core_pkg::XLEN-1:0]       data_bypass_i,
	output logic [core_pkg::REG_ADDR_W-1:0] addr_rs1_o,
	output logic [core_pkg::REG_ADDR_W-1:0] addr_rs2_o,
	output logic [core_pkg::XLEN-1:0]       cmp_a_o,
	output logic [core_pkg::XLEN-1:0]       cmp_b_o,
	output logic [core_pkg::XLEN-1:0]       jmp_target_o,
	output core_pkg::jmp_flag_t             jmp_flag_o,
	output logic                            load_hazard_o,
	output core_pkg::alu_op_t               alu_op_o,
	output logic [core_pkg::XLEN-1:0]       op_a_o,
	output logic [core_pkg::XLEN-1:0]       op_b_o,
	output logic [core_pkg::XLEN-1:0]       store_data_o,
	output logic [core_pkg::REG_ADDR_W-1:0] addr_wr_o,
	output logic                            reg_wr_en_o,
	output logic                            load_o,
	output logic                            store_o
);

	logic [6:0]                      opcode;
	logic [2:0]                      funct3;
	logic [6:0]                      funct7;
	logic [core_pkg::REG_ADDR_W-1:0] rd;
	logic [core_pkg::XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [core_pkg::XLEN-1:0]       rs1_val, rs2_val, link;
	logic                            fwd1, fwd2, use_rs1, use_rs2;
	logic                            dec_wr_en, dec_load, dec_store;
	core_pkg::alu_op_t               dec_alu_op;
	logic [core_pkg::XLEN-1:0]       dec_op_a, dec_op_b;

	assign opcode     = instr_i[6:0];
	assign funct3     = instr_i[14:12];
	assign funct7     = instr_i[31:25];
	assign rd         = instr_i[11:7];
	assign addr_rs1_o = instr_i[19:15];
	assign addr_rs2_o = instr_i[24:20];

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
	assign link  = addr_instr_i + 32'd4;

	// bypass from ex when it writes our source
	assign fwd1    = reg_wr_en_o && (addr_wr_o == addr_rs1_o);
	assign fwd2    = reg_wr_en_o && (addr_wr_o == addr_rs2_o);
	assign rs1_val = fwd1 ? data_bypass_i : data_rs1_i;
	assign rs2_val = fwd2 ? data_bypass_i : data_rs2_i;
	assign cmp_a_o = rs1_val;
	assign cmp_b_o = rs2_val;

	always_comb begin
		dec_alu_op = core_pkg::ALU_ADD;
		dec_op_a   = rs1_val;
		dec_op_b   = imm_i;
		dec_wr_en  = 1'b0;
		dec_load   = 1'b0;
		dec_store  = 1'b0;
		jmp_flag_o = core_pkg::JMP_NONE;
		use_rs1    = 1'b0;
		use_rs2    = 1'b0;
		if (!instr_mask_i) begin	// killed word decodes as nothing
			case (opcode)
				core_pkg::OPC_OP_IMM: begin
					use_rs1   = 1'b1;
					dec_wr_en = 1'b1;
					case (funct3)
						core_pkg::F3_ADD_SUB: dec_alu_op = core_pkg::ALU_ADD;
						core_pkg::F3_XOR:     dec_alu_op = core_pkg::ALU_XOR;
						core_pkg::F3_OR:      dec_alu_op = core_pkg::ALU_OR;
						core_pkg::F3_AND:     dec_alu_op = core_pkg::ALU_AND;
						default:              dec_wr_en = 1'b0;	// shifts, compares
					endcase
				end
				core_pkg::OPC_OP: begin
					use_rs1   = 1'b1;
					use_rs2   = 1'b1;
					dec_op_b  = rs2_val;
					dec_wr_en = (funct7 == core_pkg::F7_BASE);
					case (funct3)
						core_pkg::F3_ADD_SUB: begin
							dec_alu_op = (funct7 == core_pkg::F7_SUB) ? core_pkg::ALU_SUB
								: core_pkg::ALU_ADD;
							dec_wr_en  = (funct7 == core_pkg::F7_BASE) ||
								(funct7 == core_pkg::F7_SUB);
						end
						core_pkg::F3_XOR: dec_alu_op = core_pkg::ALU_XOR;
						core_pkg::F3_OR:  dec_alu_op = core_pkg::ALU_OR;
						core_pkg::F3_AND: dec_alu_op = core_pkg::ALU_AND;
						default:          dec_wr_en = 1'b0;
					endcase
				end
				core_pkg::OPC_LUI: begin
					dec_alu_op = core_pkg::ALU_PASS_B;
					dec_op_b   = imm_u;
					dec_wr_en  = 1'b1;
				end
				core_pkg::OPC_LOAD: begin
					use_rs1   = 1'b1;
					dec_load  = (funct3 == core_pkg::F3_WORD);
					dec_wr_en = dec_load;
				end
				core_pkg::OPC_STORE: begin
					use_rs1   = 1'b1;
					use_rs2   = 1'b1;
					dec_op_b  = imm_s;
					dec_store = (funct3 == core_pkg::F3_WORD);
				end
				core_pkg::OPC_BRANCH: begin
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					if (funct3 == core_pkg::F3_BEQ)
						jmp_flag_o = core_pkg::JMP_BEQ;
					else if (funct3 == core_pkg::F3_BNE)
						jmp_flag_o = core_pkg::JMP_BNE;
				end
				core_pkg::OPC_JAL: begin
					dec_op_a   = link;	// rd gets the return address
					dec_op_b   = '0;
					dec_wr_en  = 1'b1;
					jmp_flag_o = core_pkg::JMP_JAL;
				end
				default: ;
			endcase
		end
	end

	assign jmp_target_o = addr_instr_i + ((jmp_flag_o == core_pkg::JMP_JAL) ? imm_j : imm_b);

	// loaded value only exists after ex, so hold one cycle
	assign load_hazard_o = load_o && reg_wr_en_o &&
		((use_rs1 && addr_wr_o == addr_rs1_o) || (use_rs2 && addr_wr_o == addr_rs2_o));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			reg_wr_en_o <= 1'b0;
			load_o      <= 1'b0;
			store_o     <= 1'b0;
		end else if (hold_code_i != core_pkg::HOLD_ALL) begin
			reg_wr_en_o <= dec_wr_en && (rd != '0) && (hold_code_i == core_pkg::HOLD_NONE);
			load_o      <= dec_load && (hold_code_i == core_pkg::HOLD_NONE);
			store_o     <= dec_store && (hold_code_i == core_pkg::HOLD_NONE);
		end
	end

	always_ff @(posedge clk) begin
		if (hold_code_i != core_pkg::HOLD_ALL) begin
			alu_op_o     <= dec_alu_op;
			op_a_o       <= dec_op_a;
			op_b_o       <= dec_op_b;
			store_data_o <= rs2_val;
			addr_wr_o    <= rd;
		end
	end

endmodule

//--- hw/ex_stage.sv
// execute stage, alu plus the data memory and register write ports
// the alu result doubles as the load/store address; strobes and the
// register write are suppressed while the pipeline is frozen
`timescale 1ns/1ps

module ex_stage (
	input  core_pkg::hold_code_t            hold_code_i,
	input  core_pkg::alu_op_t               alu_op_i,
	input  logic [core_pkg::XLEN-1:0]       op_a_i,
	input  logic [core_pkg::XLEN-1:0]       op_b_i,
	input  logic [core_pkg::XLEN-1:0]       store_data_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] addr_wr_i,
	input  logic                            reg_wr_en_i,
	input  logic                            load_i,
	input  logic                            store_i,
	input  logic [core_pkg::XLEN-1:0]       data_mem_i,
	output logic [core_pkg::XLEN-1:0]       alu_result_o,
	output logic [core_pkg::XLEN-1:0]       data_mem_wr_o,
	output logic [core_pkg::XLEN-1:0]       addr_mem_wr_o,
	output logic [core_pkg::XLEN-1:0]       addr_mem_rd_o,
	output logic                            mem_wr_en_o,
	output logic                            mem_rd_en_o,
	output logic [core_pkg::REG_ADDR_W-1:0] addr_reg_wr_o,
	output logic [core_pkg::XLEN-1:0]       data_reg_wr_o,
	output logic                            reg_wr_en_o
);

	logic frozen;

	assign frozen = (hold_code_i == core_pkg::HOLD_ALL);

	always_comb begin
		case (alu_op_i)
			core_pkg::ALU_ADD:    alu_result_o = op_a_i + op_b_i;
			core_pkg::ALU_SUB:    alu_result_o = op_a_i - op_b_i;
			core_pkg::ALU_AND:    alu_result_o = op_a_i & op_b_i;
			core_pkg::ALU_OR:     alu_result_o = op_a_i | op_b_i;
			core_pkg::ALU_XOR:    alu_result_o = op_a_i ^ op_b_i;
			core_pkg::ALU_PASS_B: alu_result_o = op_b_i;
			default:              alu_result_o = '0;
		endcase
	end

	// word access only, address straight from the adder
	assign addr_mem_rd_o = alu_result_o;
	assign addr_mem_wr_o = alu_result_o;
	assign data_mem_wr_o = store_data_i;
	assign mem_rd_en_o   = load_i && !frozen;
	assign mem_wr_en_o   = store_i && !frozen;

	assign addr_reg_wr_o = addr_wr_i;
	assign data_reg_wr_o = load_i ? data_mem_i : alu_result_o;	// read data same cycle
	assign reg_wr_en_o   = reg_wr_en_i && !frozen;

endmodule

//--- hw/ctrl.sv
// pipeline controller
// resolves branches from the decode operands and turns stalls and load-use
// hazards into hold codes; a taken redirect kills the next fetched word
`timescale 1ns/1ps

module ctrl (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      stall_load_i,
	input  logic                      stall_store_i,
	input  logic [core_pkg::XLEN-1:0] cmp_a_i,
	input  logic [core_pkg::XLEN-1:0] cmp_b_i,
	input  logic [core_pkg::XLEN-1:0] jmp_target_i,
	input  core_pkg::jmp_flag_t       jmp_flag_i,
	input  logic                      load_hazard_i,
	output logic                      jmp_en_o,
	output logic [core_pkg::XLEN-1:0] jmp_to_o,
	output logic                      instr_mask_o,
	output core_pkg::hold_code_t      hold_code_o
);

	logic taken;
	logic mask_q;

	// stall beats load hazard beats redirect
	always_comb begin
		if (stall_load_i || stall_store_i)
			hold_code_o = core_pkg::HOLD_ALL;
		else if (load_hazard_i)
			hold_code_o = core_pkg::HOLD_FETCH;
		else
			hold_code_o = core_pkg::HOLD_NONE;
	end

	always_comb begin
		case (jmp_flag_i)
			core_pkg::JMP_BEQ: taken = (cmp_a_i == cmp_b_i);
			core_pkg::JMP_BNE: taken = (cmp_a_i != cmp_b_i);
			core_pkg::JMP_JAL: taken = 1'b1;
			default:           taken = 1'b0;
		endcase
	end

	assign jmp_en_o = taken && (hold_code_o == core_pkg::HOLD_NONE);
	assign jmp_to_o = jmp_target_i;

	// set after reset too, the word seen then is not a fetch of ours
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			mask_q <= 1'b1;
		else if (hold_code_o != core_pkg::HOLD_ALL)
			mask_q <= jmp_en_o;
	end

	assign instr_mask_o = mask_q;

endmodule

//--- hw/core.sv
// top level of the three-stage core
// connects pc, decode, execute, register file and controller to the external
// instruction and data memory ports; RESET_PC sets the first fetch address
`timescale 1ns/1ps

module core #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      stall_load_i,
	input  logic                      stall_store_i,
	input  logic [31:0]               instr_i,
	input  logic [core_pkg::XLEN-1:0] addr_instr_i,
	input  logic [core_pkg::XLEN-1:0] data_mem_i,
	output logic                      mem_wr_en_o,
	output logic                      mem_rd_en_o,
	output logic                      instr_rd_en_o,
	output logic [core_pkg::XLEN-1:0] data_mem_wr_o,
	output logic [core_pkg::XLEN-1:0] addr_mem_wr_o,
	output logic [core_pkg::XLEN-1:0] addr_mem_rd_o,
	output logic [core_pkg::XLEN-1:0] pc_o
);

	core_pkg::hold_code_t            hold_code;
	logic                            jmp_en;
	logic [core_pkg::XLEN-1:0]       jmp_to;
	logic                            instr_mask;

	logic [core_pkg::REG_ADDR_W-1:0] addr_rs1, addr_rs2;
	logic [core_pkg::XLEN-1:0]       data_rs1, data_rs2;
	logic [core_pkg::XLEN-1:0]       cmp_a, cmp_b, jmp_target;
	core_pkg::jmp_flag_t             jmp_flag;
	logic                            load_hazard;

	core_pkg::alu_op_t               alu_op;	// id/ex fields
	logic [core_pkg::XLEN-1:0]       op_a, op_b, store_data;
	logic [core_pkg::REG_ADDR_W-1:0] addr_wr;
	logic                            id_wr_en, load, store;

	logic [core_pkg::XLEN-1:0]       alu_result;
	logic [core_pkg::REG_ADDR_W-1:0] wb_addr;
	logic [core_pkg::XLEN-1:0]       wb_data;
	logic                            wb_en;

	pc #(
		.RESET_PC (RESET_PC)
	) core_pc (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.hold_code_i   (hold_code),
		.jmp_en_i      (jmp_en),
		.jmp_to_i      (jmp_to),
		.pc_o          (pc_o),
		.instr_rd_en_o (instr_rd_en_o)
	);

	id_stage core_id (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.hold_code_i   (hold_code),
		.instr_mask_i  (instr_mask),
		.instr_i       (instr_i),
		.addr_instr_i  (addr_instr_i),
		.data_rs1_i    (data_rs1),
		.data_rs2_i    (data_rs2),
		.data_bypass_i (alu_result),
		.addr_rs1_o    (addr_rs1),
		.addr_rs2_o    (addr_rs2),
		.cmp_a_o       (cmp_a),
		.cmp_b_o       (cmp_b),
		.jmp_target_o  (jmp_target),
		.jmp_flag_o    (jmp_flag),
		.load_hazard_o (load_hazard),
		.alu_op_o      (alu_op),
		.op_a_o        (op_a),
		.op_b_o        (op_b),
		.store_data_o  (store_data),
		.addr_wr_o     (addr_wr),
		.reg_wr_en_o   (id_wr_en),
		.load_o        (load),
		.store_o       (store)
	);

	ex_stage core_ex (
		.hold_code_i   (hold_code),
		.alu_op_i      (alu_op),
		.op_a_i        (op_a),
		.op_b_i        (op_b),
		.store_data_i  (store_data),
		.addr_wr_i     (addr_wr),
		.reg_wr_en_i   (id_wr_en),
		.load_i        (load),
		.store_i       (store),
		.data_mem_i    (data_mem_i),
		.alu_result_o  (alu_result),
		.data_mem_wr_o (data_mem_wr_o),
		.addr_mem_wr_o (addr_mem_wr_o),
		.addr_mem_rd_o (addr_mem_rd_o),
		.mem_wr_en_o   (mem_wr_en_o),
		.mem_rd_en_o   (mem_rd_en_o),
		.addr_reg_wr_o (wb_addr),
		.data_reg_wr_o (wb_data),
		.reg_wr_en_o   (wb_en)
	);

	regs core_regs (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.wr_en_i    (wb_en),
		.addr_wr_i  (wb_addr),
		.data_wr_i  (wb_data),
		.addr_rd1_i (addr_rs1),
		.addr_rd2_i (addr_rs2),
		.data_rd1_o (data_rs1),
		.data_rd2_o (data_rs2)
	);

	ctrl core_ctrl (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.stall_load_i  (stall_load_i),
		.stall_store_i (stall_store_i),
		.cmp_a_i       (cmp_a),
		.cmp_b_i       (cmp_b),
		.jmp_target_i  (jmp_target),
		.jmp_flag_i    (jmp_flag),
		.load_hazard_i (load_hazard),
		.jmp_en_o      (jmp_en),
		.jmp_to_o      (jmp_to),
		.instr_mask_o  (instr_mask),
		.hold_code_o   (hold_code)
	);

endmodule

//--- sim/core_props.sv
// concurrent checks on the core ports and on its controller signals
// attached to every core instance by the bind at the end of this file
`timescale 1ns/1ps

module core_props #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
	input logic                      clk,
	input logic                      arst_n_i,
	input logic                      stall_load_i,
	input logic                      stall_store_i,
	input logic                      mem_wr_en_i,
	input logic                      mem_rd_en_i,
	input logic                      instr_rd_en_i,
	input logic [core_pkg::XLEN-1:0] addr_mem_wr_i,
	input logic [core_pkg::XLEN-1:0] addr_mem_rd_i,
	input logic [core_pkg::XLEN-1:0] data_mem_wr_i,
	input logic [core_pkg::XLEN-1:0] pc_i,
	input logic                      jmp_en_i,
	input logic [core_pkg::XLEN-1:0] jmp_to_i,
	input core_pkg::hold_code_t      hold_code_i
);

	int   failures = 0;
	logic stalled;

	assign stalled = stall_load_i || stall_store_i;

	reset_pc: assert property (@(posedge clk) $rose(arst_n_i) |-> pc_i == RESET_PC)
		else begin
			failures++;
			$error("pc is not at the reset address after reset");
		end

	reset_quiet: assert property (@(posedge clk)
		!arst_n_i |-> !mem_wr_en_i && !mem_rd_en_i && !jmp_en_i && instr_rd_en_i)
		else begin
			failures++;
			$error("strobe, jump or fetch enable at the wrong level during reset");
		end

	// back-pressure blocks every memory access
	stall_no_access: assert property (@(posedge clk) disable iff (!arst_n_i)
		stalled |-> !mem_wr_en_i && !mem_rd_en_i && !instr_rd_en_i)
		else begin
			failures++;
			$error("memory access enabled during a stall");
		end

	strobes_apart: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(mem_wr_en_i && mem_rd_en_i))
		else begin
			failures++;
			$error("read and write strobes high together");
		end

	redirect_lands: assert property (@(posedge clk) disable iff (!arst_n_i)
		jmp_en_i |=> pc_i == $past(jmp_to_i))
		else begin
			failures++;
			$error("pc did not take the jump target");
		end

	stall_frozen: assert property (@(posedge clk) disable iff (!arst_n_i)
		stalled |=> $stable(pc_i) && $stable(addr_mem_wr_i) && $stable(addr_mem_rd_i)
			&& $stable(data_mem_wr_i))
		else begin
			failures++;
			$error("core outputs moved during a stall");
		end

	load_use_once: assert property (@(posedge clk) disable iff (!arst_n_i)
		hold_code_i == core_pkg::HOLD_FETCH |=> hold_code_i != core_pkg::HOLD_FETCH)
		else begin
			failures++;
			$error("load-use hold lasted more than one cycle");
		end

endmodule

bind core core_props #(
	.RESET_PC (RESET_PC)
) props (
	.clk           (clk),
	.arst_n_i      (arst_n_i),
	.stall_load_i  (stall_load_i),
	.stall_store_i (stall_store_i),
	.mem_wr_en_i   (mem_wr_en_o),
	.mem_rd_en_i   (mem_rd_en_o),
	.instr_rd_en_i (instr_rd_en_o),
	.addr_mem_wr_i (addr_mem_wr_o),
	.addr_mem_rd_i (addr_mem_rd_o),
	.data_mem_wr_i (data_mem_wr_o),
	.pc_i          (pc_o),
	.jmp_en_i      (jmp_en),
	.jmp_to_i      (jmp_to),
	.hold_code_i   (hold_code)
);

//--- sim/core_tb.sv
// testbench for the three-stage core
// runs a fixed program from a rom model under random stalls and checks every
// store against a table worked out from the instruction semantics
`timescale 1ns/1ps

module core_tb;

	localparam logic [31:0] RESET_PC        = 32'h0;
	localparam int          PROG_LEN        = 35;
	localparam int          NUM_STORES      = 13;
	localparam int          WATCHDOG_CYCLES = PROG_LEN * 6 + 200;
	localparam logic [31:0] POISON_ADDR     = 32'h0000_00fc;
	localparam logic [31:0] LOAD_ADDR       = 32'h0000_0020;

	logic        clk;
	logic        arst_n_i;
	logic        stall_load_i;
	logic        stall_store_i;
	logic [31:0] instr_i;
	logic [31:0] addr_instr_i;
	logic [31:0] data_mem_i;
	logic        mem_wr_en_o;
	logic        mem_rd_en_o;
	logic        instr_rd_en_o;
	logic [31:0] data_mem_wr_o;
	logic [31:0] addr_mem_wr_o;
	logic [31:0] addr_mem_rd_o;
	logic [31:0] pc_o;

	logic [31:0] rom [64];
	logic [31:0] dmem [64];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	string       exp_name [$];
	int          stores_seen;
	int          store_errors;
	int          poison_errors;
	int          loads_seen;
	int          load_errors;
	int          burst;
	integer      seed;
	logic [31:0] rnd;

	core #(
		.RESET_PC (RESET_PC)
	) dut (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.stall_load_i  (stall_load_i),
		.stall_store_i (stall_store_i),
		.instr_i       (instr_i),
		.addr_instr_i  (addr_instr_i),
		.data_mem_i    (data_mem_i),
		.mem_wr_en_o   (mem_wr_en_o),
		.mem_rd_en_o   (mem_rd_en_o),
		.instr_rd_en_o (instr_rd_en_o),
		.data_mem_wr_o (data_mem_wr_o),
		.addr_mem_wr_o (addr_mem_wr_o),
		.addr_mem_rd_o (addr_mem_rd_o),
		.pc_o          (pc_o)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] op_reg(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] fill_word(input int idx);
		return 32'h1000_0000 + idx * 32'h0001_0004;	// every word distinct
	endfunction

	task automatic load_program();
		for (int i = 0; i < 64; i++)
			rom[i] = 32'h0000_0013;	// nop
		rom[0]  = op_imm(3'b000, 5'd1, 5'd0, 12'h5a3);
		rom[1]  = op_imm(3'b000, 5'd2, 5'd1, 12'hf00);	// -256
		rom[2]  = op_reg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
		rom[3]  = op_reg(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
		rom[4]  = op_reg(7'h00, 3'b111, 5'd5, 5'd3, 5'd1);
		rom[5]  = op_reg(7'h00, 3'b110, 5'd6, 5'd3, 5'd2);
		rom[6]  = op_reg(7'h00, 3'b100, 5'd7, 5'd6, 5'd4);
		rom[7]  = store_word(5'd7, 5'd0, 12'h040);
		rom[8]  = store_word(5'd2, 5'd0, 12'h044);
		rom[9]  = store_word(5'd3, 5'd0, 12'h048);
		rom[10] = store_word(5'd4, 5'd0, 12'h04c);
		rom[11] = store_word(5'd5, 5'd0, 12'h050);
		rom[12] = store_word(5'd6, 5'd0, 12'h054);
		rom[13] = lui(5'd8, 20'habcde);
		rom[14] = op_imm(3'b110, 5'd9, 5'd8, 12'h123);
		rom[15] = op_imm(3'b100, 5'd10, 5'd9, 12'hfff);
		rom[16] = op_imm(3'b111, 5'd11, 5'd10, 12'h0f0);
		rom[17] = store_word(5'd8, 5'd0, 12'h058);
		rom[18] = store_word(5'd11, 5'd0, 12'h05c);
		rom[19] = store_word(5'd10, 5'd0, 12'h060);
		rom[20] = op_imm(3'b000, 5'd0, 5'd1, 12'h007);
		rom[21] = store_word(5'd0, 5'd0, 12'h064);
		rom[22] = load_word(5'd12, 5'd0, LOAD_ADDR[11:0]);
		rom[23] = op_reg(7'h00, 3'b000, 5'd13, 5'd12, 5'd1);	// uses the load at once
		rom[24] = store_word(5'd13, 5'd0, 12'h068);
		rom[25] = branch(3'b000, 5'd4, 5'd2, 13'd8);	// beq taken
		rom[26] = store_word(5'd1, 5'd0, POISON_ADDR[11:0]);
		rom[27] = branch(3'b001, 5'd1, 5'd2, 13'd8);	// bne taken
		rom[28] = store_word(5'd1, 5'd0, POISON_ADDR[11:0]);
		rom[29] = branch(3'b000, 5'd1, 5'd2, 13'd8);	// beq falls through
		rom[30] = store_word(5'd9, 5'd0, 12'h06c);
		rom[31] = jal(5'd14, 21'd8);
		rom[32] = store_word(5'd1, 5'd0, POISON_ADDR[11:0]);
		rom[33] = store_word(5'd14, 5'd0, 12'h070);
		rom[34] = jal(5'd0, 21'd0);	// park here
	endtask

	task automatic expect_store(input string name, input logic [31:0] addr,
			input logic [31:0] data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// register values follow the program above
	task automatic load_expected();
		logic [31:0] r1, r2, r3, r4, r5, r6, r7;
		logic [31:0] r8, r9, r10, r11, r13, r14;
		r1  = 32'h5a3;
		r2  = r1 - 32'd256;
		r3  = r1 + r2;
		r4  = r3 - r1;
		r5  = r3 & r1;
		r6  = r3 | r2;
		r7  = r6 ^ r4;
		r8  = 32'habcde << 12;
		r9  = r8 | 32'h123;
		r10 = r9 ^ 32'hffff_ffff;
		r11 = r10 & 32'h0f0;
		r13 = fill_word(LOAD_ADDR >> 2) + r1;
		r14 = 32'd31 * 4 + 4;	// return address of the jal
		expect_store("xor_chain", 32'h40, r7);
		expect_store("addi_fwd", 32'h44, r2);
		expect_store("add", 32'h48, r3);
		expect_store("sub", 32'h4c, r4);
		expect_store("and", 32'h50, r5);
		expect_store("or", 32'h54, r6);
		expect_store("lui", 32'h58, r8);
		expect_store("andi", 32'h5c, r11);
		expect_store("xori", 32'h60, r10);
		expect_store("x0_write", 32'h64, 32'h0);
		expect_store("load_use", 32'h68, r13);
		expect_store("beq_not_taken", 32'h6c, r9);
		expect_store("jal_link", 32'h70, r14);
	endtask

	always @(posedge clk) begin
		if (instr_rd_en_o) begin
			instr_i      <= rom[pc_o[7:2]];
			addr_instr_i <= pc_o;
		end
	end

	assign data_mem_i = mem_rd_en_o ? dmem[addr_mem_rd_o[7:2]] : 32'h0;

	always @(posedge clk) begin
		if (!arst_n_i) begin
			stall_load_i  <= 1'b0;
			stall_store_i <= 1'b0;
			burst         <= 0;
		end else if (burst > 0) begin
			burst <= burst - 1;
		end else begin
			rnd = $random(seed);
			if (rnd[2:0] == 3'd0) begin	// start a burst of 1 to 4 cycles
				stall_load_i  <= rnd[3] | rnd[6];
				stall_store_i <= !rnd[3] | rnd[6];
				burst         <= rnd[5:4];
			end else begin
				stall_load_i  <= 1'b0;
				stall_store_i <= 1'b0;
			end
		end
	end

	// the program has a single load
	always @(posedge clk) begin
		if (mem_rd_en_o) begin
			assert (addr_mem_rd_o == LOAD_ADDR) else begin
				load_errors++;
				$display("** Error load_addr: expected %h, actual %h",
					LOAD_ADDR, addr_mem_rd_o);
			end
			loads_seen++;
		end
	end

	always @(posedge clk) begin
		if (mem_wr_en_o) begin
			dmem[addr_mem_wr_o[7:2]] <= data_mem_wr_o;
			assert (addr_mem_wr_o != POISON_ADDR) else begin
				poison_errors++;
				$display("skipped instruction executed, store to poison address %h",
					addr_mem_wr_o);
			end
			assert (stores_seen < NUM_STORES) else begin
				store_errors++;
				$display("store to %h after the last expected store", addr_mem_wr_o);
			end
			if (addr_mem_wr_o != POISON_ADDR && stores_seen < NUM_STORES) begin
				assert (addr_mem_wr_o == exp_addr[stores_seen] &&
					data_mem_wr_o == exp_data[stores_seen]) else begin
					store_errors++;
					$display("** Error %s: expected %h @ %h, actual %h @ %h",
						exp_name[stores_seen], exp_data[stores_seen], exp_addr[stores_seen],
						data_mem_wr_o, addr_mem_wr_o);
				end
				stores_seen++;
			end
		end
	end

	initial begin
		clk           = 1'b0;
		arst_n_i      = 1'b0;
		stall_load_i  = 1'b0;
		stall_store_i = 1'b0;
		instr_i       = 32'h0000_0013;
		addr_instr_i  = 32'h0;
		seed          = 58460;
		load_program();
		load_expected();
		for (int i = 0; i < 64; i++)
			dmem[i] = fill_word(i);
		repeat (8) @(posedge clk);
		arst_n_i <= 1'b1;
		wait (stores_seen == NUM_STORES);
		repeat (20) @(posedge clk);	// room for a stray store
		if (loads_seen != 1) begin
			load_errors++;
			$display("expected one data memory read, saw %0d", loads_seen);
		end
		$display("stores %0d/%0d, errors: store %0d load %0d poison %0d assertion %0d",
			stores_seen, NUM_STORES, store_errors, load_errors, poison_errors,
			dut.props.failures);
		if (store_errors + load_errors + poison_errors + dut.props.failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, only %0d of %0d stores seen in %0d cycles",
			stores_seen, NUM_STORES, WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- list.f
hw/core_pkg.sv
hw/pc.sv
hw/regs.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/ctrl.sv
hw/core.sv
sim/core_props.sv
sim/core_tb.sv
